/* flist.f */
hw/capture_pkg.sv
hw/capture_config_regs.sv
hw/video_to_ram.sv
hw/line_buffer_ram.sv
hw/capture_top.sv
tests/capture_sva.sv
tests/capture_tb.sv

/* Bender.yml */
package:
  name: capture

sources:
  - hw/capture_pkg.sv
  - hw/capture_config_regs.sv
  - hw/video_to_ram.sv
  - hw/line_buffer_ram.sv
  - hw/capture_top.sv
  - target: test
    files:
      - tests/capture_sva.sv
      - tests/capture_tb.sv

/* tests/capture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_tb import capture_pkg::*; ();

    localparam int          CLK_PERIOD      = 20;
    localparam int          NUM_FRAMES      = 7;
    localparam int          MAX_LINES       = 360;
    localparam int          MAX_LINE_CLOCKS = 110;
    localparam logic [11:0] IDLE            = 12'd4000;

    logic                     clock;
    logic                     nreset;
    cfg_write_t               cfg;
    pixel_t                   pixel;
    logic [COUNTER_WIDTH-1:0] counter_x;
    logic [COUNTER_WIDTH-1:0] counter_y;
    logic                     line_doubler;
    logic                     is_pal;
    logic [RAM_WIDTH-1:0]     rd_addr;
    pixel_t                   rd_data;
    ram_write_t               ram_wr;
    logic                     start_trigger;

    logic [31:0]     lcg_state;
    int              errors;
    int              tests_done;
    int              writes_seen;
    int              triggers_seen;
    int              last_y_written;
    int              full_wraps;
    int              outside_resets;
    logic [11:0]     y_prev;
    logic            ld_prev;
    logic            pal_prev;

    // Reference model state.
    capture_config_t mcfg;
    logic            m_ld;
    logic            m_pal;
    logic [11:0]     m_xprev;
    logic [14:0]     m_base;
    logic [14:0]     m_addr;
    logic            exp_en;
    logic            exp_trig;
    logic [14:0]     exp_addr;
    pixel_t          exp_data;
    pixel_t          shadow [int];
    int              written_q [$];

    capture_top UUT (
        .clock         (clock),
        .nreset        (nreset),
        .cfg           (cfg),
        .pixel         (pixel),
        .counter_x     (counter_x),
        .counter_y     (counter_y),
        .line_doubler  (line_doubler),
        .is_pal        (is_pal),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .ram_wr        (ram_wr),
        .start_trigger (start_trigger)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[30:15]};
    endfunction

    // ============================================================
    // Reference model, one step per clock on last cycle's inputs
    // ============================================================
    always @(posedge clock or negedge nreset) begin : model
        int hs, he, vs, ve, fe, f2;
        logic [14:0] tr, limit, addr_n;
        logic [11:0] y_off;
        logic vcap, cap;
        if (!nreset) begin
            mcfg     = CONFIG_DEFAULT;
            m_ld     = 1'b0;
            m_pal    = 1'b0;
            m_xprev  = '0;
            m_base   = '0;
            m_addr   = '0;
            exp_en   = 1'b0;
            exp_trig = 1'b0;
        end else begin
            hs = m_ld ? mcfg.i_h_start : mcfg.p_h_start;
            he = m_ld ? mcfg.i_h_end : mcfg.p_h_end;
            vs = m_ld ? mcfg.i_v_start : mcfg.p_v_start;
            ve = m_ld ? mcfg.i_v_end : mcfg.p_v_end;
            tr = m_ld ? mcfg.trigger_address_i : mcfg.trigger_address_p;
            fe = m_pal ? 288 : 240;
            f2 = m_pal ? 312 : 262;
            if (m_ld) begin
                vcap = (counter_y < fe) || (counter_y > f2 && counter_y < ve);
            end else begin
                vcap = (counter_y >= vs) && (counter_y < ve);
            end
            cap    = vcap && counter_x >= hs && counter_x < he;
            addr_n = m_base + 15'(counter_x - hs);
            y_off  = counter_y - 12'(vs);
            exp_en   = cap;
            exp_trig = cap && (y_off < 12'(mcfg.buffer_size)) && (m_addr == tr);
            if (cap) begin
                exp_addr = addr_n;
                exp_data = pixel;
                shadow[addr_n] = pixel;
                written_q.push_back(addr_n);
                m_addr = addr_n;
            end
            if (m_xprev == 12'(he) && counter_x == 12'(he)) begin
                limit = mcfg.ram_numwords - mcfg.buffer_line_length;
                if (vcap && m_base < limit) begin
                    m_base = m_base + mcfg.buffer_line_length;
                end else begin
                    if (vcap) full_wraps++;
                    else if (m_base != 0) outside_resets++;
                    m_base = '0;
                end
            end
            m_ld    = line_doubler;
            m_pal   = is_pal;
            m_xprev = counter_x;
            if (cfg.strobe) begin
                case (cfg.sel)
                    CFG_P_H_START:    mcfg.p_h_start = cfg.data[9:0];
                    CFG_P_H_END:      mcfg.p_h_end = cfg.data[9:0];
                    CFG_P_V_START:    mcfg.p_v_start = cfg.data[9:0];
                    CFG_P_V_END:      mcfg.p_v_end = cfg.data[9:0];
                    CFG_I_H_START:    mcfg.i_h_start = cfg.data[9:0];
                    CFG_I_H_END:      mcfg.i_h_end = cfg.data[9:0];
                    CFG_I_V_START:    mcfg.i_v_start = cfg.data[9:0];
                    CFG_I_V_END:      mcfg.i_v_end = cfg.data[9:0];
                    CFG_LINE_LENGTH:  mcfg.buffer_line_length = cfg.data[14:0];
                    CFG_BUFFER_SIZE:  mcfg.buffer_size = cfg.data[9:0];
                    CFG_RAM_NUMWORDS: mcfg.ram_numwords = cfg.data[14:0];
                    CFG_TRIGGER_P:    mcfg.trigger_address_p = cfg.data[14:0];
                    CFG_TRIGGER_I:    mcfg.trigger_address_i = cfg.data[14:0];
                    default: ;
                endcase
            end
        end
    end

    always @(posedge clock) begin
        y_prev   <= counter_y;
        ld_prev  <= line_doubler;
        pal_prev <= is_pal;
    end

    // ============================================================
    // Output checks on the falling edge
    // ============================================================
    always @(negedge clock) begin
        if (nreset) begin
            if (ram_wr.en !== exp_en) begin
                $display("[FAIL] ram_wr.en exp %h got %h", exp_en, ram_wr.en);
                errors++;
            end else if (exp_en) begin
                writes_seen++;
                last_y_written = y_prev;
                if (ram_wr.addr !== exp_addr) begin
                    $display("[FAIL] ram_wr.addr exp %h got %h", exp_addr, ram_wr.addr);
                    errors++;
                end
                if (ram_wr.data !== exp_data) begin
                    $display("[FAIL] ram_wr.data exp %h got %h", exp_data, ram_wr.data);
                    errors++;
                end
            end
            if (start_trigger !== exp_trig) begin
                $display("[FAIL] start_trigger exp %h got %h", exp_trig, start_trigger);
                errors++;
            end else if (exp_trig) begin
                triggers_seen++;
            end
            // The field gap of the interlaced window is never written.
            if (ram_wr.en && m_ld && ld_prev && y_prev >= (pal_prev ? 288 : 240)
                    && y_prev <= (pal_prev ? 312 : 262)) begin
                $display("Line %0d inside the field gap was written", y_prev);
                errors++;
            end
        end
    end

    initial begin
        #(NUM_FRAMES * MAX_LINES * MAX_LINE_CLOCKS * CLK_PERIOD + 40000);
        $display("Timeout: the watchdog stopped the simulation");
        $display("Regression failed");
        $finish;
    end

    task automatic write_cfg(input cfg_reg_e sel, input int value);
        @(posedge clock);
        cfg <= '{strobe: 1'b1, sel: sel, data: 16'(value)};
        @(posedge clock);
        cfg.strobe <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            counter_x <= IDLE;
            counter_y <= IDLE;
        end
    endtask

    // Raster with the last column held for one extra clock.
    task automatic run_frame(input int y_last, input int x_last);
        logic [31:0] r;
        for (int y = 0; y <= y_last; y++) begin
            for (int x = 0; x <= x_last + 1; x++) begin
                r = rand_next() ^ (rand_next() << 12);
                @(posedge clock);
                counter_x <= 12'((x > x_last) ? x_last : x);
                counter_y <= 12'(y);
                pixel     <= pixel_t'(r[23:0]);
            end
        end
        idle_cycles(4);
    endtask

    task automatic end_test(input string name, input int err_before, input bit extra_ok);
        if (!extra_ok) begin
            $display("Test %s: the expected capture activity did not occur", name);
            errors++;
        end
        tests_done++;
        $display("Test %-12s done, %0d errors", name, errors - err_before);
    endtask

    initial begin
        int e0, w0, hs, width, ll, k, ivs;
        int pvs, wraps0, resets0;
        logic [31:0] r;
        clock = 1'b0;
        nreset = 1'b0;
        cfg = '{strobe: 1'b0, sel: CFG_P_H_START, data: '0};
        pixel = '0;
        counter_x = IDLE;
        counter_y = IDLE;
        line_doubler = 1'b0;
        is_pal = 1'b0;
        rd_addr = '0;
        lcg_state = 32'd76;
        errors = 0;
        tests_done = 0;
        writes_seen = 0;
        triggers_seen = 0;
        last_y_written = -1;
        full_wraps = 0;
        outside_resets = 0;
        repeat (8) @(posedge clock);
        nreset <= 1'b1;
        idle_cycles(4);

        // Defaults keep the first lines out, a new window lets them in.
        e0 = errors;
        run_frame(4, 99);
        w0 = writes_seen;
        write_cfg(CFG_P_H_START, 8);
        write_cfg(CFG_P_H_END, 40);
        write_cfg(CFG_P_V_START, 0);
        write_cfg(CFG_P_V_END, 10);
        idle_cycles(2);
        run_frame(3, 40);
        end_test("reset_cfg", e0, w0 == 0 && writes_seen == 128);

        // Random progressive geometry that wraps within one frame.
        // The captured line count is never a multiple of k.
        hs = 4 + rand_next() % 16;
        width = 16 + rand_next() % 32;
        ll = width + rand_next() % 16;
        k = 3 + rand_next() % 3;
        pvs = 1 + rand_next() % 8;
        write_cfg(CFG_P_H_START, hs);
        write_cfg(CFG_P_H_END, hs + width);
        write_cfg(CFG_P_V_START, pvs);
        write_cfg(CFG_P_V_END, pvs + 3 * k + 1 + rand_next() % (k - 1));
        write_cfg(CFG_LINE_LENGTH, ll);
        write_cfg(CFG_RAM_NUMWORDS, ll * k);
        write_cfg(CFG_BUFFER_SIZE, 8);
        write_cfg(CFG_TRIGGER_P, ll + rand_next() % (width - 1));
        idle_cycles(2);
        e0 = errors;
        w0 = writes_seen;
        run_frame(30, hs + width);
        end_test("progressive", e0, writes_seen > w0);

        e0 = errors;
        wraps0 = full_wraps;
        resets0 = outside_resets;
        run_frame(30, hs + width);
        end_test("line_wrap", e0, full_wraps > wraps0 && outside_resets > resets0);

        e0 = errors;
        w0 = triggers_seen;
        run_frame(30, hs + width);
        end_test("trigger_p", e0, triggers_seen > w0);

        // Interlaced window with NTSC and PAL field gaps.
        ivs = rand_next() % 4;
        hs = 4 + rand_next() % 16;
        write_cfg(CFG_I_H_START, hs);
        write_cfg(CFG_I_H_END, hs + width);
        write_cfg(CFG_I_V_START, ivs);
        write_cfg(CFG_I_V_END, 330 + rand_next() % 16);
        write_cfg(CFG_TRIGGER_I, ll + rand_next() % (width - 1));
        line_doubler <= 1'b1;
        idle_cycles(3);
        e0 = errors;
        w0 = triggers_seen;
        last_y_written = -1;
        run_frame(mcfg.i_v_end + 1, hs + width);
        end_test("interl_ntsc", e0,
                 last_y_written == mcfg.i_v_end - 1 && triggers_seen > w0);
        is_pal <= 1'b1;
        idle_cycles(3);
        e0 = errors;
        w0 = triggers_seen;
        last_y_written = -1;
        run_frame(mcfg.i_v_end + 1, hs + width);
        end_test("interl_pal", e0,
                 last_y_written == mcfg.i_v_end - 1 && triggers_seen > w0);

        // Read back through the registered port.
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            r = written_q[rand_next() % written_q.size()];
            @(posedge clock);
            rd_addr <= 15'(r);
            @(posedge clock);
            @(negedge clock);
            if (rd_data !== shadow[r]) begin
                $display("[FAIL] rd_data exp %h got %h", shadow[r], rd_data);
                errors++;
            end
        end
        end_test("readback", e0, 1'b1);

        if (UUT.u_video_to_ram.u_capture_sva.failures != 0) begin
            $display("The capture assertions failed %0d times",
                     UUT.u_video_to_ram.u_capture_sva.failures);
            errors += UUT.u_video_to_ram.u_capture_sva.failures;
        end

        $display("Tests %0d, writes %0d, triggers %0d, errors %0d",
                 tests_done, writes_seen, triggers_seen, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/capture_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_sva import capture_pkg::*; (
    input logic            clock,
    input logic            nreset,
    input ram_write_t      ram_wr,
    input logic            start_trigger,
    input capture_config_t capture_cfg
);

    int failures = 0;

    // A trigger only comes with a write.
    assert property (@(posedge clock) disable iff (!nreset)
        start_trigger |-> ram_wr.en)
        else begin
            $error("start_trigger high without a RAM write");
            failures++;
        end

    assert property (@(posedge clock)
        !nreset |-> (!ram_wr.en && !start_trigger))
        else begin
            $error("capture outputs active during reset");
            failures++;
        end

    assert property (@(posedge clock) disable iff (!nreset)
        ram_wr.en |-> (ram_wr.addr < capture_cfg.ram_numwords))
        else begin
            $error("RAM write address beyond ram_numwords");
            failures++;
        end

endmodule

bind video_to_ram capture_sva u_capture_sva (
    .clock         (clock),
    .nreset        (nreset),
    .ram_wr        (ram_wr),
    .start_trigger (start_trigger),
    .capture_cfg   (capture_cfg)
);

`default_nettype wire

/* hw/capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_top import capture_pkg::*; (
    input  logic                     clock,
    input  logic                     nreset,
    input  cfg_write_t               cfg,
    input  pixel_t                   pixel,
    input  logic [COUNTER_WIDTH-1:0] counter_x,
    input  logic [COUNTER_WIDTH-1:0] counter_y,
    input  logic                     line_doubler,
    input  logic                     is_pal,
    input  logic [RAM_WIDTH-1:0]     rd_addr,
    output pixel_t                   rd_data,
    output ram_write_t               ram_wr,
    output logic                     start_trigger
);

    capture_config_t capture_cfg;

    // ============================================================
    // Configuration registers
    // ============================================================
    capture_config_regs u_config_regs (
        .clock       (clock),
        .nreset      (nreset),
        .cfg         (cfg),
        .capture_cfg (capture_cfg)
    );

    // ============================================================
    // Window test and address generation
    // ============================================================
    video_to_ram u_video_to_ram (
        .clock         (clock),
        .nreset        (nreset),
        .pixel         (pixel),
        .counter_x     (counter_x),
        .counter_y     (counter_y),
        .line_doubler  (line_doubler),
        .is_pal        (is_pal),
        .capture_cfg   (capture_cfg),
        .ram_wr        (ram_wr),
        .start_trigger (start_trigger)
    );

    // ============================================================
    // Line buffer
    // ============================================================
    line_buffer_ram u_line_buffer_ram (
        .clock   (clock),
        .wr      (ram_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* hw/line_buffer_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_ram import capture_pkg::*; (
    input  logic                 clock,
    input  ram_write_t           wr,
    input  logic [RAM_WIDTH-1:0] rd_addr,
    output pixel_t               rd_data
);

    pixel_t mem [RAM_WORDS];

    logic   wr_in_range;
    logic   rd_in_range;

    // The address space is wider than the memory.
    assign wr_in_range = (wr.addr < RAM_WIDTH'(RAM_WORDS));
    assign rd_in_range = (rd_addr < RAM_WIDTH'(RAM_WORDS));

    // ============================================================
    // Write port
    // ============================================================
    always_ff @(posedge clock) begin
        if (wr.en && wr_in_range) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // ============================================================
    // Registered read port
    // ============================================================
    always_ff @(posedge clock) begin
        if (rd_in_range) begin
            rd_data <= mem[rd_addr];
        end else begin
            rd_data <= '0;
        end
    end

endmodule

`default_nettype wire

/* hw/video_to_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module video_to_ram import capture_pkg::*; (
    input  logic                     clock,
    input  logic                     nreset,
    input  pixel_t                   pixel,
    input  logic [COUNTER_WIDTH-1:0] counter_x,
    input  logic [COUNTER_WIDTH-1:0] counter_y,
    input  logic                     line_doubler,
    input  logic                     is_pal,
    input  capture_config_t          capture_cfg,
    output ram_write_t               ram_wr,
    output logic                     start_trigger
);

    logic                     line_doubler_q;
    logic                     is_pal_q;
    logic [COUNTER_WIDTH-1:0] counter_x_prev;
    logic [RAM_WIDTH-1:0]     line_base;

    logic                     wr_en_q;
    logic [RAM_WIDTH-1:0]     wr_addr_q;
    pixel_t                   wr_data_q;
    logic                     trigger_q;

    logic [COUNTER_WIDTH-1:0] h_start;
    logic [COUNTER_WIDTH-1:0] h_end;
    logic [COUNTER_WIDTH-1:0] v_start;
    logic [COUNTER_WIDTH-1:0] v_end;
    logic [COUNTER_WIDTH-1:0] field_end;
    logic [COUNTER_WIDTH-1:0] field2_start;
    logic [RAM_WIDTH-1:0]     trigger_addr;

    logic                     v_capture;
    logic                     h_capture;
    logic                     capture;
    logic                     line_end;
    logic [COUNTER_WIDTH-1:0] x_offset;
    logic [COUNTER_WIDTH-1:0] y_offset;
    logic [RAM_WIDTH-1:0]     wr_addr_next;
    logic [RAM_WIDTH-1:0]     base_limit;
    logic                     trigger_hit;

    // ============================================================
    // Active window, chosen by the registered line doubler
    // ============================================================
    always_comb begin
        if (line_doubler_q) begin
            h_start      = COUNTER_WIDTH'(capture_cfg.i_h_start);
            h_end        = COUNTER_WIDTH'(capture_cfg.i_h_end);
            v_start      = COUNTER_WIDTH'(capture_cfg.i_v_start);
            v_end        = COUNTER_WIDTH'(capture_cfg.i_v_end);
            trigger_addr = capture_cfg.trigger_address_i;
        end else begin
            h_start      = COUNTER_WIDTH'(capture_cfg.p_h_start);
            h_end        = COUNTER_WIDTH'(capture_cfg.p_h_end);
            v_start      = COUNTER_WIDTH'(capture_cfg.p_v_start);
            v_end        = COUNTER_WIDTH'(capture_cfg.p_v_end);
            trigger_addr = capture_cfg.trigger_address_p;
        end
    end

    assign field_end    = is_pal_q ? PAL_FIELD_END : NTSC_FIELD_END;
    assign field2_start = is_pal_q ? PAL_FIELD2_START : NTSC_FIELD2_START;

    // Interlaced mode skips the blanking gap between the two fields.
    always_comb begin
        if (line_doubler_q) begin
            v_capture = (counter_y < field_end)
                     || (counter_y > field2_start && counter_y < v_end);
        end else begin
            v_capture = (counter_y >= v_start) && (counter_y < v_end);
        end
    end

    assign h_capture = (counter_x >= h_start) && (counter_x < h_end);
    assign capture   = v_capture && h_capture;

    assign x_offset     = counter_x - h_start;
    assign y_offset     = counter_y - v_start;
    assign wr_addr_next = line_base + RAM_WIDTH'(x_offset);
    assign base_limit   = capture_cfg.ram_numwords - capture_cfg.buffer_line_length;

    // Compares against the address of the previous write.
    assign trigger_hit = (y_offset < COUNTER_WIDTH'(capture_cfg.buffer_size))
                      && (wr_addr_q == trigger_addr);

    // The end column held for two cycles marks the end of a line.
    assign line_end = (counter_x_prev == h_end) && (counter_x == h_end);

    // ============================================================
    // Control and address registers
    // ============================================================
    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            line_doubler_q <= 1'b0;
            is_pal_q       <= 1'b0;
            counter_x_prev <= '0;
            line_base      <= '0;
            wr_en_q        <= 1'b0;
            wr_addr_q      <= '0;
            trigger_q      <= 1'b0;
        end else begin
            line_doubler_q <= line_doubler;
            is_pal_q       <= is_pal;
            counter_x_prev <= counter_x;

            if (line_end) begin
                if (v_capture && line_base < base_limit) begin
                    line_base <= line_base + capture_cfg.buffer_line_length;
                end else begin
                    line_base <= '0;
                end
            end

            wr_en_q   <= capture;
            trigger_q <= capture && trigger_hit;
            if (capture) begin
                wr_addr_q <= wr_addr_next;
            end
        end
    end

    // Pixel payload.
    always_ff @(posedge clock) begin
        if (capture) begin
            wr_data_q <= pixel;
        end
    end

    assign ram_wr        = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};
    assign start_trigger = trigger_q;

endmodule

`default_nettype wire

/* hw/capture_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_config_regs import capture_pkg::*; (
    input  logic            clock,
    input  logic            nreset,
    input  cfg_write_t      cfg,
    output capture_config_t capture_cfg
);

    // ============================================================
    // One field per strobe, truncated to the field width
    // ============================================================
    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            capture_cfg <= CONFIG_DEFAULT;
        end else if (cfg.strobe) begin
            case (cfg.sel)
                CFG_P_H_START: begin
                    capture_cfg.p_h_start <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_P_H_END: begin
                    capture_cfg.p_h_end <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_P_V_START: begin
                    capture_cfg.p_v_start <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_P_V_END: begin
                    capture_cfg.p_v_end <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_I_H_START: begin
                    capture_cfg.i_h_start <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_I_H_END: begin
                    capture_cfg.i_h_end <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_I_V_START: begin
                    capture_cfg.i_v_start <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_I_V_END: begin
                    capture_cfg.i_v_end <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_LINE_LENGTH: begin
                    capture_cfg.buffer_line_length <= cfg.data[RAM_WIDTH-1:0];
                end
                CFG_BUFFER_SIZE: begin
                    capture_cfg.buffer_size <= cfg.data[WINDOW_WIDTH-1:0];
                end
                CFG_RAM_NUMWORDS: begin
                    capture_cfg.ram_numwords <= cfg.data[RAM_WIDTH-1:0];
                end
                CFG_TRIGGER_P: begin
                    capture_cfg.trigger_address_p <= cfg.data[RAM_WIDTH-1:0];
                end
                CFG_TRIGGER_I: begin
                    capture_cfg.trigger_address_i <= cfg.data[RAM_WIDTH-1:0];
                end
                default: begin
                    // Unused select codes leave the register alone.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/capture_pkg.sv */
`default_nettype none

package capture_pkg;

    // ============================================================
    // Sizes
    // ============================================================
    localparam int RAM_WIDTH      = 15;
    localparam int RAM_WORDS      = 24576;
    localparam int COUNTER_WIDTH  = 12;
    localparam int WINDOW_WIDTH   = 10;
    localparam int CFG_DATA_WIDTH = 16;

    // Interlaced field gaps, in source lines.
    localparam logic [COUNTER_WIDTH-1:0] PAL_FIELD_END      = 12'd288;
    localparam logic [COUNTER_WIDTH-1:0] PAL_FIELD2_START   = 12'd312;
    localparam logic [COUNTER_WIDTH-1:0] NTSC_FIELD_END     = 12'd240;
    localparam logic [COUNTER_WIDTH-1:0] NTSC_FIELD2_START  = 12'd262;

    // ============================================================
    // Types
    // ============================================================
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic [WINDOW_WIDTH-1:0] p_h_start;
        logic [WINDOW_WIDTH-1:0] p_h_end;
        logic [WINDOW_WIDTH-1:0] p_v_start;
        logic [WINDOW_WIDTH-1:0] p_v_end;
        logic [WINDOW_WIDTH-1:0] i_h_start;
        logic [WINDOW_WIDTH-1:0] i_h_end;
        logic [WINDOW_WIDTH-1:0] i_v_start;
        logic [WINDOW_WIDTH-1:0] i_v_end;
        logic [RAM_WIDTH-1:0]    buffer_line_length;
        logic [WINDOW_WIDTH-1:0] buffer_size;
        logic [RAM_WIDTH-1:0]    ram_numwords;
        logic [RAM_WIDTH-1:0]    trigger_address_p;
        logic [RAM_WIDTH-1:0]    trigger_address_i;
    } capture_config_t;

    typedef enum logic [3:0] {
        CFG_P_H_START,
        CFG_P_H_END,
        CFG_P_V_START,
        CFG_P_V_END,
        CFG_I_H_START,
        CFG_I_H_END,
        CFG_I_V_START,
        CFG_I_V_END,
        CFG_LINE_LENGTH,
        CFG_BUFFER_SIZE,
        CFG_RAM_NUMWORDS,
        CFG_TRIGGER_P,
        CFG_TRIGGER_I
    } cfg_reg_e;

    typedef struct packed {
        logic                      strobe;
        cfg_reg_e                  sel;
        logic [CFG_DATA_WIDTH-1:0] data;
    } cfg_write_t;

    typedef struct packed {
        logic                 en;
        logic [RAM_WIDTH-1:0] addr;
        pixel_t               data;
    } ram_write_t;

    // ============================================================
    // Reset values of the configuration
    // ============================================================
    localparam logic [WINDOW_WIDTH-1:0] DEF_P_H_START    = 10'd44;
    localparam logic [WINDOW_WIDTH-1:0] DEF_P_H_END      = 10'd684;
    localparam logic [WINDOW_WIDTH-1:0] DEF_P_V_START    = 10'd35;
    localparam logic [WINDOW_WIDTH-1:0] DEF_P_V_END      = 10'd515;
    localparam logic [WINDOW_WIDTH-1:0] DEF_I_H_START    = 10'd44;
    localparam logic [WINDOW_WIDTH-1:0] DEF_I_H_END      = 10'd684;
    localparam logic [WINDOW_WIDTH-1:0] DEF_I_V_START    = 10'd0;
    localparam logic [WINDOW_WIDTH-1:0] DEF_I_V_END      = 10'd600;
    localparam logic [RAM_WIDTH-1:0]    DEF_LINE_LENGTH  = 15'd640;
    localparam logic [WINDOW_WIDTH-1:0] DEF_BUFFER_SIZE  = 10'd16;
    localparam logic [RAM_WIDTH-1:0]    DEF_RAM_NUMWORDS = 15'd24320;
    localparam logic [RAM_WIDTH-1:0]    DEF_TRIGGER_P    = 15'd5120;
    localparam logic [RAM_WIDTH-1:0]    DEF_TRIGGER_I    = 15'd5120;

    localparam capture_config_t CONFIG_DEFAULT = '{
        p_h_start:          DEF_P_H_START,
        p_h_end:            DEF_P_H_END,
        p_v_start:          DEF_P_V_START,
        p_v_end:            DEF_P_V_END,
        i_h_start:          DEF_I_H_START,
        i_h_end:            DEF_I_H_END,
        i_v_start:          DEF_I_V_START,
        i_v_end:            DEF_I_V_END,
        buffer_line_length: DEF_LINE_LENGTH,
        buffer_size:        DEF_BUFFER_SIZE,
        ram_numwords:       DEF_RAM_NUMWORDS,
        trigger_address_p:  DEF_TRIGGER_P,
        trigger_address_i:  DEF_TRIGGER_I
    };

endpackage

`default_nettype wire
